// ==== source/jtag_cmd_pkg.sv ====
`default_nettype none

package jtag_cmd_pkg;

    // commands understood by the TAP engine
    typedef enum logic [2:0] {
        CMD_CLOSE_TEST = 3'd0,  // five tms-high cycles into reset
        CMD_RUN_TEST   = 3'd1,  // one tms-low cycle into idle
        CMD_LOAD_IR    = 3'd2,  // arg is the instruction code
        CMD_LOAD_DR    = 3'd3,  // arg is the bit count
        CMD_IDLE_DELAY = 3'd4   // arg is tck cycles in idle
    } jtag_cmd_e;

    localparam int CMD_ARG_W = 16;

    // configuration program
    localparam int PROG_STEPS = 12;
    localparam int CFGI_DELAY = 64;  // tck cycles after CFGI
    localparam int WAKE_DELAY = 16;  // tck cycles after JWAKEUP

    // engine queue depth, also the sequencer's starting credit
    localparam int CMD_CREDITS = 2;

endpackage

`default_nettype wire

// ==== source/jtag_tap_pkg.sv ====
`default_nettype none

package jtag_tap_pkg;

    // IEEE 1149.1 state encoding
    typedef enum logic [3:0] {
        TAP_EXIT2_DR   = 4'h0,
        TAP_EXIT1_DR   = 4'h1,
        TAP_SHIFT_DR   = 4'h2,
        TAP_PAUSE_DR   = 4'h3,
        TAP_SELECT_IR  = 4'h4,
        TAP_UPDATE_DR  = 4'h5,
        TAP_CAPTURE_DR = 4'h6,
        TAP_SELECT_DR  = 4'h7,
        TAP_EXIT2_IR   = 4'h8,
        TAP_EXIT1_IR   = 4'h9,
        TAP_SHIFT_IR   = 4'hA,
        TAP_PAUSE_IR   = 4'hB,
        TAP_IDLE       = 4'hC,
        TAP_UPDATE_IR  = 4'hD,
        TAP_CAPTURE_IR = 4'hE,
        TAP_RESET      = 4'hF
    } tap_state_e;

    localparam int IR_LEN = 10;

    localparam logic [IR_LEN-1:0] IR_JRST    = 10'h0F7;
    localparam logic [IR_LEN-1:0] IR_CFGI    = 10'h0C4;
    localparam logic [IR_LEN-1:0] IR_JWAKEUP = 10'h0C7;

    localparam logic [1:0] IR_CAPTURE_OK = 2'b01;  // bit 0 shifts out first

    localparam int BIT_FIFO_DEPTH = 16;
    localparam int BIT_CNT_W      = $clog2(BIT_FIFO_DEPTH) + 1;

endpackage

`default_nettype wire

// ==== source/jtag_cmd_seq.sv ====
`default_nettype none

module jtag_cmd_seq
    import jtag_cmd_pkg::*;
    import jtag_tap_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [CMD_ARG_W-1:0] bitstream_len,
    input  logic                 cmd_credit,
    output logic                 cmd_valid,
    output jtag_cmd_e            cmd_op,
    output logic [CMD_ARG_W-1:0] cmd_arg,
    output logic                 busy,
    output logic                 done
);

    logic [$clog2(PROG_STEPS+1)-1:0]  step;     // next step to issue
    logic [$clog2(PROG_STEPS+1)-1:0]  retired;  // commands given back
    logic [$clog2(CMD_CREDITS+1)-1:0] credits;
    logic [CMD_ARG_W-1:0]             len_q;

    assign cmd_valid = busy && (step < PROG_STEPS) && (credits != '0);

    // configuration program
    always_comb begin
        cmd_op  = CMD_CLOSE_TEST;  // steps 0, 7 and 11
        cmd_arg = '0;
        case (step)
            1, 3, 8: cmd_op = CMD_RUN_TEST;
            2: begin
                cmd_op  = CMD_LOAD_IR;
                cmd_arg = CMD_ARG_W'(IR_JRST);
            end
            4: begin
                cmd_op  = CMD_LOAD_IR;
                cmd_arg = CMD_ARG_W'(IR_CFGI);
            end
            5: begin
                cmd_op  = CMD_IDLE_DELAY;
                cmd_arg = CMD_ARG_W'(CFGI_DELAY);
            end
            6: begin
                cmd_op  = CMD_LOAD_DR;
                cmd_arg = len_q;  // bitstream
            end
            9: begin
                cmd_op  = CMD_LOAD_IR;
                cmd_arg = CMD_ARG_W'(IR_JWAKEUP);
            end
            10: begin
                cmd_op  = CMD_IDLE_DELAY;
                cmd_arg = CMD_ARG_W'(WAKE_DELAY);
            end
            default: cmd_op = CMD_CLOSE_TEST;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step    <= '0;
            retired <= '0;
            credits <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy    <= 1'b1;
                step    <= '0;
                retired <= '0;
                credits <= CMD_CREDITS[$bits(credits)-1:0];  // engine queue is empty
            end else if (busy) begin
                if (cmd_valid) begin
                    step <= step + 1'b1;
                end
                if (cmd_valid && !cmd_credit) begin
                    credits <= credits - 1'b1;
                end else if (!cmd_valid && cmd_credit) begin
                    credits <= credits + 1'b1;
                end
                if (cmd_credit) begin
                    retired <= retired + 1'b1;
                    if (retired == PROG_STEPS - 1) begin  // last command retired
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            len_q <= bitstream_len;
        end
    end

endmodule

`default_nettype wire

// ==== source/jtag_bit_fifo.sv ====
`default_nettype none

module jtag_bit_fifo
    import jtag_tap_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic bit_valid,
    input  logic bit_data,
    input  logic bit_rd,
    output logic bit_rd_data,
    output logic bit_empty,
    output logic bit_credit
);

    logic                 mem [BIT_FIFO_DEPTH];
    logic [BIT_CNT_W-1:0] wr_ptr;  // msb is the wrap bit
    logic [BIT_CNT_W-1:0] rd_ptr;

    assign bit_empty   = (wr_ptr == rd_ptr);
    assign bit_rd_data = mem[rd_ptr[BIT_CNT_W-2:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            bit_credit <= 1'b0;
        end else begin
            if (bit_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // source holds a credit, so never full
            end
            if (bit_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            bit_credit <= bit_rd;  // slot freed, hand it back
        end
    end

    always_ff @(posedge clk) begin
        if (bit_valid) begin
            mem[wr_ptr[BIT_CNT_W-2:0]] <= bit_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/jtag_tap_engine.sv ====
`default_nettype none

module jtag_tap_engine
    import jtag_cmd_pkg::*;
    import jtag_tap_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 cmd_valid,
    input  jtag_cmd_e            cmd_op,
    input  logic [CMD_ARG_W-1:0] cmd_arg,
    output logic                 cmd_credit,
    output logic                 bit_rd,
    input  logic                 bit_rd_data,
    input  logic                 bit_empty,
    output logic                 tck,
    output logic                 tms,
    output logic                 tdi,
    input  logic                 tdo,
    output logic                 error
);

    jtag_cmd_e                        q_op  [CMD_CREDITS];
    logic [CMD_ARG_W-1:0]             q_arg [CMD_CREDITS];
    logic [$clog2(CMD_CREDITS)-1:0]   q_wr;
    logic [$clog2(CMD_CREDITS)-1:0]   q_rd;
    logic [$clog2(CMD_CREDITS+1)-1:0] q_cnt;

    tap_state_e           state;     // mirror of the target TAP
    logic                 phase;     // next clk raises tck
    logic [CMD_ARG_W-1:0] cnt;       // cycles or shifted bits
    logic                 upd_done;  // load passed Update

    jtag_cmd_e            op;
    logic [CMD_ARG_W-1:0] arg;
    logic [CMD_ARG_W-1:0] shift_len;
    logic                 have_cmd, is_load, is_ir, need_bit;
    logic                 fin, ready, pop, plan_tms, shift_bit;

    function automatic tap_state_e tap_next(input tap_state_e s, input logic m);
        case (s)
            TAP_RESET:      tap_next = m ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       tap_next = m ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  tap_next = m ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: tap_next = m ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   tap_next = m ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   tap_next = m ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   tap_next = m ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   tap_next = m ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  tap_next = m ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  tap_next = m ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: tap_next = m ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   tap_next = m ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   tap_next = m ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   tap_next = m ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   tap_next = m ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  tap_next = m ? TAP_SELECT_DR : TAP_IDLE;
            default:        tap_next = TAP_RESET;
        endcase
    endfunction

    assign have_cmd  = (q_cnt != '0);
    assign op        = q_op[q_rd];
    assign arg       = q_arg[q_rd];
    assign is_ir     = (op == CMD_LOAD_IR);
    assign is_load   = is_ir || (op == CMD_LOAD_DR);
    assign shift_len = is_ir ? CMD_ARG_W'(IR_LEN) : arg;
    assign need_bit  = (op == CMD_LOAD_DR) && (state == TAP_SHIFT_DR);
    assign ready     = have_cmd && !fin && !(need_bit && bit_empty);  // stall on empty FIFO
    assign pop       = have_cmd && fin && !phase;
    assign bit_rd    = !phase && ready && need_bit;

    always_comb begin
        case (op)
            CMD_CLOSE_TEST: fin = (cnt == CMD_ARG_W'(5));
            CMD_RUN_TEST:   fin = (cnt == CMD_ARG_W'(1));
            CMD_IDLE_DELAY: fin = (cnt == arg);
            default:        fin = upd_done;  // back in idle
        endcase
    end

    // tms toward the goal of the head command
    always_comb begin
        plan_tms = (op == CMD_CLOSE_TEST);
        if (is_load) begin
            case (state)
                TAP_IDLE:       plan_tms = 1'b1;
                TAP_SELECT_DR:  plan_tms = is_ir;
                TAP_SELECT_IR:  plan_tms = !is_ir;
                TAP_CAPTURE_DR,
                TAP_CAPTURE_IR: plan_tms = (shift_len == '0);
                TAP_SHIFT_DR,
                TAP_SHIFT_IR:   plan_tms = (cnt == shift_len - 1'b1);  // last bit
                TAP_RESET,
                TAP_UPDATE_DR,
                TAP_UPDATE_IR:  plan_tms = 1'b0;
                default:        plan_tms = 1'b1;  // exit and pause go to update
            endcase
        end
    end

    always_comb begin
        shift_bit = 1'b0;
        if (need_bit) begin
            shift_bit = bit_rd_data;
        end else if (state == TAP_SHIFT_IR) begin
            shift_bit = arg[cnt[$clog2(CMD_ARG_W)-1:0]];  // lsb first
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            q_op[q_wr]  <= cmd_op;
            q_arg[q_wr] <= cmd_arg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_cnt <= '0;
        end else begin
            if (cmd_valid) begin
                q_wr <= q_wr + 1'b1;
            end
            if (pop) begin
                q_rd <= q_rd + 1'b1;
            end
            if (cmd_valid && !pop) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (!cmd_valid && pop) begin
                q_cnt <= q_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= 1'b0;
            tck        <= 1'b0;
            tms        <= 1'b1;
            tdi        <= 1'b0;
            state      <= TAP_RESET;
            cnt        <= '0;
            upd_done   <= 1'b0;
            cmd_credit <= 1'b0;
            error      <= 1'b0;
        end else begin
            cmd_credit <= pop;
            if (!phase) begin
                tck <= 1'b0;
                if (pop) begin
                    cnt      <= '0;
                    upd_done <= 1'b0;
                end else if (ready) begin
                    tms   <= plan_tms;
                    tdi   <= shift_bit;
                    phase <= 1'b1;
                end
            end else begin
                tck   <= 1'b1;  // target moves on this edge
                phase <= 1'b0;
                state <= tap_next(state, tms);
                if (!is_load || state == TAP_SHIFT_DR || state == TAP_SHIFT_IR) begin
                    cnt <= cnt + 1'b1;
                end
                if (state == TAP_UPDATE_DR || state == TAP_UPDATE_IR) begin
                    upd_done <= 1'b1;
                end
                // first two bits out of Shift-IR are the capture pattern
                if (state == TAP_SHIFT_IR && cnt < CMD_ARG_W'(2)
                        && tdo != IR_CAPTURE_OK[cnt[0]]) begin
                    error <= 1'b1;
                end
            end
            if (start) begin
                error <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/jtag_config_top.sv ====
`default_nettype none

module jtag_config_top
    import jtag_cmd_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [CMD_ARG_W-1:0] bitstream_len,
    input  logic                 bit_valid,
    input  logic                 bit_data,
    output logic                 bit_credit,
    output logic                 tck,
    output logic                 tms,
    output logic                 tdi,
    input  logic                 tdo,
    output logic                 busy,
    output logic                 done,
    output logic                 error
);

    // command channel
    logic                 cmd_valid;
    jtag_cmd_e            cmd_op;
    logic [CMD_ARG_W-1:0] cmd_arg;
    logic                 cmd_credit;

    // FIFO read side
    logic                 bit_rd;
    logic                 bit_rd_data;
    logic                 bit_empty;

    jtag_cmd_seq u_seq (.*);

    jtag_bit_fifo u_fifo (.*);

    jtag_tap_engine u_engine (.*);

endmodule

`default_nettype wire

// ==== bench/jtag_config_chk.sv ====
`default_nettype none

module jtag_config_chk
    import jtag_cmd_pkg::*;
    import jtag_tap_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic start,
    input wire logic busy,
    input wire logic done,
    input wire logic bit_valid,
    input wire logic bit_credit,
    input wire logic tck,
    input wire logic tms,
    input wire logic tdi,
    input wire logic cmd_valid,
    input wire logic cmd_credit
);
    timeunit 1ns;
    timeprecision 100ps;

    int src_cnt;  // credits the bit source still holds
    int seq_cnt;  // credits the sequencer still holds

    always_ff @(posedge clk) begin
        if (rst) begin
            src_cnt <= BIT_FIFO_DEPTH;
            seq_cnt <= 0;
        end else begin
            src_cnt <= src_cnt + int'(bit_credit) - int'(bit_valid);
            if (start && !busy) begin
                seq_cnt <= CMD_CREDITS;
            end else begin
                seq_cnt <= seq_cnt + int'(cmd_credit) - int'(cmd_valid);
            end
        end
    end

    // a credit returned this cycle may be spent in the same cycle
    a_bit_credit: assert property (@(posedge clk) disable iff (rst)
        bit_valid |-> src_cnt + int'(bit_credit) > 0)
        else $error("bit pushed without source credit");

    a_pins_steady: assert property (@(posedge clk) disable iff (rst)
        tck |-> $stable(tms) && $stable(tdi)) else $error("tms or tdi moved with tck high");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy && $past(busy) ##1 !done) else $error("done is not a one-cycle end pulse");

    a_cmd_credit: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> seq_cnt > 0) else $error("command issued without credit");

endmodule

`default_nettype wire

// ==== bench/jtag_tap_monitor.sv ====
`default_nettype none

module jtag_tap_monitor
    import jtag_cmd_pkg::*;
    import jtag_tap_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire logic [CMD_ARG_W-1:0] bitstream_len,
    input  wire logic                 bit_valid,
    input  wire logic                 bit_data,
    input  wire logic                 tck,
    input  wire logic                 tms,
    input  wire logic                 tdi,
    output logic                      tdo,
    input  wire logic                 busy,
    input  wire logic                 done,
    input  wire logic                 error,
    input  wire logic                 corrupt,
    input  int                        test_id,
    output int                        tests_run,
    output int                        fail_count
);
    timeunit 1ns;
    timeprecision 100ps;

    tap_state_e        s = TAP_RESET;  // target TAP model
    logic [IR_LEN-1:0] ir;
    int                ir_idx, dr_n, idle_n, ones, ev_fails = 0, ev_base;
    logic [31:0]       exp_q[$];  // {kind, value}
    logic              src_q[$];  // bits pushed by the source
    logic              rst_q = 1'b1, start_q = 1'b0, ok;

    // event kind 1 is reset, 2 idle run, 3 IR update and 4 DR update
    function automatic logic [31:0] pack_event(input logic [3:0] kind, input logic [27:0] val);
        return {kind, val};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0: return "full_37";
            1: return "throttled";
            2: return "corrupt_capture";
            default: return "restart_5";
        endcase
    endfunction

    function automatic tap_state_e tap_step(input tap_state_e st, input logic m);
        case (st)
            TAP_RESET: return m ? TAP_RESET : TAP_IDLE;
            TAP_IDLE: return m ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR: return m ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_SELECT_IR: return m ? TAP_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_DR, TAP_SHIFT_DR: return m ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_CAPTURE_IR, TAP_SHIFT_IR: return m ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_DR: return m ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_EXIT1_IR: return m ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_DR: return m ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_PAUSE_IR: return m ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_DR: return m ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_EXIT2_IR: return m ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            default: return m ? TAP_SELECT_DR : TAP_IDLE;  // both update states
        endcase
    endfunction

    // expected event list of one configuration program
    task automatic build_expected(input int len);
        exp_q.delete();
        exp_q.push_back(pack_event(1, TAP_RESET));
        exp_q.push_back(pack_event(2, 0));
        exp_q.push_back(pack_event(3, IR_JRST));
        exp_q.push_back(pack_event(2, 1));
        exp_q.push_back(pack_event(3, IR_CFGI));
        exp_q.push_back(pack_event(2, CFGI_DELAY));
        exp_q.push_back(pack_event(4, len));
        exp_q.push_back(pack_event(2, 0));
        exp_q.push_back(pack_event(1, TAP_RESET));
        exp_q.push_back(pack_event(2, 0));
        exp_q.push_back(pack_event(3, IR_JWAKEUP));
        exp_q.push_back(pack_event(2, WAKE_DELAY));
        exp_q.push_back(pack_event(1, TAP_RESET));
    endtask

    task automatic take_event(input logic [31:0] got);
        logic [31:0] want;
        if (exp_q.size() == 0) begin
            $display("%s: unexpected TAP event %h", test_name(test_id), got);
            ev_fails++;
        end else begin
            want = exp_q.pop_front();
            if (want != got) begin
                $display("CHECK FAILED %s: expected %h actual %h", test_name(test_id), want, got);
                ev_fails++;
            end
        end
    endtask

    // target shifts out the capture pattern first
    assign tdo = (s == TAP_SHIFT_IR && ir_idx < 2) ? (IR_CAPTURE_OK[ir_idx[0]] ^ corrupt) : 1'b0;

    always @(posedge tck) begin
        tap_state_e ns;
        logic       want_bit;
        ns = tap_step(s, tms);
        if (s == TAP_IDLE) begin
            if (tms) begin
                take_event(pack_event(2, idle_n));
                idle_n = 0;
            end else begin
                idle_n++;
            end
        end
        if (s == TAP_SHIFT_IR) begin
            ir = {tdi, ir[IR_LEN-1:1]};  // lsb arrives first
            ir_idx++;
        end
        if (s == TAP_SHIFT_DR) begin
            dr_n++;
            if (src_q.size() == 0) begin
                $display("%s: DR shifted a bit the source never pushed", test_name(test_id));
                ev_fails++;
            end else begin
                want_bit = src_q.pop_front();
                if (want_bit != tdi) begin
                    $display("CHECK FAILED %s: expected %b actual %b", test_name(test_id),
                             want_bit, tdi);
                    ev_fails++;
                end
            end
        end
        if (ns == TAP_CAPTURE_IR) ir_idx = 0;
        if (ns == TAP_CAPTURE_DR) dr_n = 0;
        if (ns == TAP_UPDATE_DR) take_event(pack_event(4, dr_n));
        if (ns == TAP_UPDATE_IR) begin
            take_event(pack_event(3, ir));
            if (error != corrupt) begin
                $display("CHECK FAILED %s: expected %b actual %b", test_name(test_id),
                         corrupt, error);
                ev_fails++;
            end
        end
        ones = tms ? ones + 1 : 0;
        if (ones == 5) begin  // a full close sequence
            take_event(pack_event(1, ns));
            ones = 0;
        end
        s = ns;
    end

    always @(posedge clk) begin
        if (rst) begin
            tests_run  = 0;
            fail_count = 0;
        end else begin
            if (rst_q) begin
                // tck, tms, tdi, busy, done, error
                ok = ({tck, tms, tdi, busy, done, error} == 6'b010000);
                if (!ok) $display("CHECK FAILED reset_pins: expected %b actual %b", 6'b010000,
                                  {tck, tms, tdi, busy, done, error});
                $display("test reset_pins: %s", ok ? "ok" : "failed");
                tests_run++;
                fail_count += int'(!ok);
            end
            if (start_q && error) begin
                $display("%s: error did not clear at start", test_name(test_id));
                ev_fails++;
            end
            if (start && !busy) begin
                build_expected(int'(bitstream_len));
                ev_base = ev_fails;
            end
            if (bit_valid) src_q.push_back(bit_data);
            if (done) begin
                ok = (exp_q.size() == 0) && (src_q.size() == 0);
                if (!ok) $display("%s: program ended with events or bits left over",
                                  test_name(test_id));
                if (error != corrupt) begin
                    $display("CHECK FAILED %s: expected %b actual %b", test_name(test_id),
                             corrupt, error);
                    ok = 1'b0;
                end
                ok = ok && (ev_fails == ev_base);
                $display("test %s: %s", test_name(test_id), ok ? "ok" : "failed");
                tests_run++;
                fail_count += int'(!ok);
            end
        end
        rst_q   = rst;
        start_q = start && !busy;
    end

endmodule

`default_nettype wire

// ==== bench/jtag_config_tb.sv ====
`default_nettype none

module jtag_config_tb
    import jtag_cmd_pkg::*;
    import jtag_tap_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOTAL_LEN      = 37 + 40 + 12 + 5;  // longest lengths used
    localparam int TIMEOUT_CYCLES =
        2 * 2 * (4 * (CFGI_DELAY + WAKE_DELAY + 4 * (IR_LEN + 6) + 30) + TOTAL_LEN);

    logic                 clk, rst, start, bit_valid, bit_data, bit_credit;
    logic [CMD_ARG_W-1:0] bitstream_len;
    logic                 tck, tms, tdi, tdo, busy, done, error, corrupt;
    int                   test_id, tests_run, fail_count, src_credits;
    int                   cycle = 0;
    logic [7:0]           lfsr = 8'd95;

    jtag_config_top DUT (.*);

    jtag_tap_monitor u_mon (.*);

    bind jtag_config_top jtag_config_chk u_chk (.*);

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[7];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic run_program(input int id, input int len, input logic throttle,
                               input logic bad_tdo);
        int   sent;
        logic b, go, finished;
        @(posedge clk);
        #1;
        test_id       = id;
        corrupt       = bad_tdo;
        start         = 1'b1;
        bitstream_len = CMD_ARG_W'(len);
        sent          = 0;
        finished      = 1'b0;
        while (!finished) begin
            @(posedge clk);
            #1;
            start     = 1'b0;
            bit_valid = 1'b0;
            finished  = done;
            if (bit_credit) src_credits++;
            go = 1'b1;
            if (throttle) take_bit(go);  // push only on a one
            if (sent < len && src_credits > 0 && go) begin
                take_bit(b);
                bit_valid = 1'b1;
                bit_data  = b;
                src_credits--;
                sent++;
            end
        end
        repeat (3) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [4:0] r;
        rst           = 1'b1;
        start         = 1'b0;
        bitstream_len = '0;
        bit_valid     = 1'b0;
        bit_data      = 1'b0;
        corrupt       = 1'b0;
        test_id       = 0;
        repeat (3) @(posedge clk);
        #1;
        rst         = 1'b0;
        src_credits = BIT_FIFO_DEPTH;
        for (int i = 0; i < 5; i++) begin
            take_bit(r[i]);
        end
        run_program(0, 37, 1'b0, 1'b0);
        run_program(1, 8 + int'(r), 1'b1, 1'b0);
        run_program(2, 12, 1'b0, 1'b1);
        run_program(3, 5, 1'b0, 1'b0);
        $display("tests run %0d, failed %0d", tests_run, fail_count);
        if (fail_count == 0 && tests_run == 5) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/jtag_cmd_pkg.sv
source/jtag_tap_pkg.sv
source/jtag_cmd_seq.sv
source/jtag_bit_fifo.sv
source/jtag_tap_engine.sv
source/jtag_config_top.sv
bench/jtag_config_chk.sv
bench/jtag_tap_monitor.sv
bench/jtag_config_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = jtag_config_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
